// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Integer data path width
`define XLEN 32

// Architectural register count, x0 included
`define NUM_REGS 32

// Multiplier iterations per product
`define MUL_STEPS 4

`endif

// File: hw/riscv_isa_pkg.sv
package riscv_isa_pkg;

  // Major opcodes handled by the execute subsystem
  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_t;

  // R-type function codes
  typedef enum logic [6:0] {
    F7_ADD = 7'b0000000,
    F7_SUB = 7'b0100000,
    F7_MUL = 7'b0000001
  } funct7_t;

  // Branch conditions in funct3
  localparam logic [2:0] BR_EQ = 3'b000;
  localparam logic [2:0] BR_NE = 3'b001;

  // R-type layout
  typedef struct packed {
    funct7_t    funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_inst_t;

  // I-type layout, same word seen with a 12-bit immediate
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_inst_t;

endpackage

// File: hw/exec_pkg.sv
`include "core_settings.svh"

package exec_pkg;

  // Class from the main decoder
  typedef enum logic [1:0] {
    CLS_IMM_STORE = 2'b00,
    CLS_BRANCH    = 2'b01,
    CLS_RTYPE     = 2'b10,
    CLS_JUMP      = 2'b11
  } alu_class_t;

  // Operation from the ALU control block
  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_MUL = 2'b10
  } alu_op_t;

  // Micro-op handed to the ALU stage or the multiplier
  typedef struct packed {
    alu_op_t          alu_op;
    logic [4:0]       rd;
    logic             we;
    logic             is_branch;
    // Branch taken on not-equal when set
    logic             br_ne;
    logic             is_jump;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
  } issue_t;

endpackage

// File: hw/wb_if.sv
`include "core_settings.svh"

interface wb_if;

  // Write request from one producer
  logic             req;
  logic [4:0]       rd;
  logic [`XLEN-1:0] data;

  // Accepted on the edge that ends a cycle with grant high
  logic             grant;

  // Producer holds req, rd and data until granted
  modport producer (output req, output rd, output data, input grant);

  modport arbiter (input req, input rd, input data, output grant);

endinterface

// File: hw/alu_control.sv
module alu_control
  import riscv_isa_pkg::*, exec_pkg::*;
(
  input  alu_class_t cu_alu_op,
  input  funct7_t    funct7,
  output alu_op_t    alu_op,
  output logic       is_mul,
  output logic       set_nop
);

  always_comb
  begin
    // Defaults cover every path
    alu_op  = ALU_ADD;
    is_mul  = 1'b0;
    set_nop = 1'b0;

    case (cu_alu_op)
      // Immediate arithmetic adds
      CLS_IMM_STORE: alu_op = ALU_ADD;

      // Compare by subtraction
      CLS_BRANCH: alu_op = ALU_SUB;

      CLS_RTYPE:
      begin
        case (funct7)
          F7_ADD: alu_op = ALU_ADD;
          F7_SUB: alu_op = ALU_SUB;
          F7_MUL:
          begin
            alu_op = ALU_MUL;
            is_mul = 1'b1;
          end
          // Unlisted funct7 runs as add
          default: alu_op = ALU_ADD;
        endcase
      end

      // Jump kills the following instruction
      CLS_JUMP:
      begin
        alu_op  = ALU_ADD;
        set_nop = 1'b1;
      end

      default: alu_op = ALU_ADD;
    endcase
  end

endmodule

// File: hw/issue_unit.sv
`include "core_settings.svh"

module issue_unit
  import riscv_isa_pkg::*, exec_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             inst_valid,
  input  r_inst_t          inst,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  input  logic             mul_busy,
  input  logic [4:0]       mul_rd,
  input  logic             alu_hold,
  output logic [4:0]       rs1_addr,
  output logic [4:0]       rs2_addr,
  output logic             stall,
  output logic             alu_start,
  output logic             mul_start,
  output issue_t           op
);

  alu_class_t       cls;
  alu_op_t          alu_op;
  i_inst_t          inst_i;
  logic [`XLEN-1:0] imm;
  logic             known;
  logic             uses_rs1;
  logic             uses_rs2;
  logic             use_imm;
  logic             writes_rd;
  logic             rd_we;
  logic             is_mul;
  logic             set_nop;
  logic             hazard;
  logic             accept;
  logic             active;
  logic             squash;

  // Same word viewed as I-type for the immediate
  assign inst_i = inst;
  assign imm    = {{(`XLEN - 12){inst_i.imm[11]}}, inst_i.imm};

  // Main decoder
  always_comb
  begin
    cls       = CLS_IMM_STORE;
    known     = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    use_imm   = 1'b0;
    writes_rd = 1'b0;
    case (inst.opcode)
      OP_R:
      begin
        cls       = CLS_RTYPE;
        known     = 1'b1;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        writes_rd = 1'b1;
      end
      OP_IMM:
      begin
        cls       = CLS_IMM_STORE;
        known     = 1'b1;
        uses_rs1  = 1'b1;
        use_imm   = 1'b1;
        writes_rd = 1'b1;
      end
      OP_BRANCH:
      begin
        cls      = CLS_BRANCH;
        // Only beq and bne are executed
        known    = (inst.funct3 == BR_EQ) || (inst.funct3 == BR_NE);
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OP_JAL:
      begin
        cls   = CLS_JUMP;
        known = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  alu_control alu_control_inst (
    .cu_alu_op (cls),
    .funct7    (inst.funct7),
    .alu_op    (alu_op),
    .is_mul    (is_mul),
    .set_nop   (set_nop)
  );

  // x0 is never a write target
  assign rd_we = writes_rd && (inst.rd != 5'd0);

  // Pending multiply blocks a second mul and any RAW or WAW on its rd
  assign hazard = mul_busy && (is_mul
                  || (uses_rs1 && inst.rs1 == mul_rd)
                  || (uses_rs2 && inst.rs2 == mul_rd)
                  || (rd_we && inst.rd == mul_rd));

  assign stall  = inst_valid && (alu_hold || hazard);
  assign accept = inst_valid && !stall;
  assign active = accept && known && !squash;

  // Mul to x0 has no effect and is dropped here
  assign alu_start = active && !is_mul;
  assign mul_start = active && is_mul && rd_we;

  assign rs1_addr = inst.rs1;
  assign rs2_addr = inst.rs2;

  always_comb
  begin
    op.alu_op    = alu_op;
    op.rd        = inst.rd;
    op.we        = rd_we;
    op.is_branch = (cls == CLS_BRANCH);
    op.br_ne     = (inst.funct3 == BR_NE);
    op.is_jump   = (cls == CLS_JUMP);
    op.src_a     = rs1_data;
    op.src_b     = use_imm ? imm : rs2_data;
  end

  // Squash set by a jump, consumed by the next accepted word
  always_ff @(posedge clk)
  begin
    if (rst)
      squash <= 1'b0;
    else if (accept)
      squash <= !squash && set_nop;
  end

endmodule

// File: hw/register_file.sv
`include "core_settings.svh"

module register_file (
  input  logic             clk,
  input  logic             rst,
  input  logic [4:0]       rs1_addr,
  input  logic [4:0]       rs2_addr,
  output logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] rs2_data,
  input  logic             we,
  input  logic [4:0]       waddr,
  input  logic [`XLEN-1:0] wdata
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // Whole file cleared on reset
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (we && waddr != 5'd0)
      regs[waddr] <= wdata;
  end

  // x0 reads zero
  // Same-cycle write is forwarded so results chain back to back
  assign rs1_data = (rs1_addr == 5'd0) ? '0
                  : (we && waddr == rs1_addr) ? wdata
                  : regs[rs1_addr];

  assign rs2_data = (rs2_addr == 5'd0) ? '0
                  : (we && waddr == rs2_addr) ? wdata
                  : regs[rs2_addr];

endmodule

// File: hw/alu_stage.sv
`include "core_settings.svh"

module alu_stage
  import exec_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       alu_start,
  input  issue_t     op,
  wb_if.producer     wb,
  output logic       branch_taken,
  output logic       redirect,
  output logic       alu_hold
);

  logic [`XLEN-1:0] result;
  logic             zero;

  // Add or subtract, mul never arrives here
  always_comb
  begin
    case (op.alu_op)
      ALU_SUB: result = op.src_a - op.src_b;
      default: result = op.src_a + op.src_b;
    endcase
  end

  // Equality test on the difference
  assign zero = (result == '0);

  // Request flag
  always_ff @(posedge clk)
  begin
    if (rst)
      wb.req <= 1'b0;
    else if (alu_start && op.we)
      wb.req <= 1'b1;
    else if (wb.grant)
      wb.req <= 1'b0;
  end

  // Payload, loaded only with a new request
  always_ff @(posedge clk)
  begin
    if (alu_start && op.we)
    begin
      wb.rd   <= op.rd;
      wb.data <= result;
    end
  end

  // One-cycle control pulses
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      branch_taken <= 1'b0;
      redirect     <= 1'b0;
    end
    else
    begin
      branch_taken <= alu_start && op.is_branch && (zero != op.br_ne);
      redirect     <= alu_start && op.is_jump;
    end
  end

  // Waiting on the write port, issue must stop
  assign alu_hold = wb.req && !wb.grant;

  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    alu_start |-> !alu_hold);

  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    alu_hold |=> wb.req && $stable(wb.rd) && $stable(wb.data));

endmodule

// File: hw/iter_multiplier.sv
`include "core_settings.svh"

module iter_multiplier
  import exec_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       mul_start,
  input  issue_t     op,
  wb_if.producer     wb,
  output logic       mul_busy,
  output logic [4:0] mul_rd
);

  // Multiplier bits retired per cycle
  localparam int STEP_W = `XLEN / `MUL_STEPS;
  localparam int CNT_W  = $clog2(`MUL_STEPS);

  logic [`XLEN-1:0] mcand;
  logic [`XLEN-1:0] mplier;
  logic [`XLEN-1:0] acc;
  logic [CNT_W-1:0] step;
  logic             busy;

  // Control, first slice is done on the start edge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy   <= 1'b0;
      wb.req <= 1'b0;
      step   <= '0;
    end
    else if (mul_start)
    begin
      busy <= 1'b1;
      step <= CNT_W'(1);
    end
    else if (wb.grant)
    begin
      busy   <= 1'b0;
      wb.req <= 1'b0;
    end
    else if (busy && !wb.req)
    begin
      step <= step + 1'b1;
      // Last slice lands with the request
      if (step == CNT_W'(`MUL_STEPS - 1))
        wb.req <= 1'b1;
    end
  end

  // Shift-and-add datapath, only the low XLEN bits are kept
  always_ff @(posedge clk)
  begin
    if (mul_start)
    begin
      acc    <= op.src_a * op.src_b[STEP_W-1:0];
      mcand  <= op.src_a << STEP_W;
      mplier <= op.src_b >> STEP_W;
      wb.rd  <= op.rd;
    end
    else if (busy && !wb.req)
    begin
      acc    <= acc + mcand * mplier[STEP_W-1:0];
      mcand  <= mcand << STEP_W;
      mplier <= mplier >> STEP_W;
    end
  end

  assign wb.data  = acc;
  assign mul_busy = busy;
  assign mul_rd   = wb.rd;

  a_start_idle: assert property (@(posedge clk) disable iff (rst)
    mul_start |-> !busy);

  // Multiplier has top priority on the write port
  a_mul_granted: assert property (@(posedge clk) disable iff (rst)
    wb.req |-> wb.grant);

endmodule

// File: hw/wb_arbiter.sv
`include "core_settings.svh"

module wb_arbiter (
  input  logic             clk,
  input  logic             rst,
  wb_if.arbiter            alu_wb,
  wb_if.arbiter            mul_wb,
  output logic             we,
  output logic [4:0]       waddr,
  output logic [`XLEN-1:0] wdata,
  output logic             wb_valid,
  output logic [4:0]       wb_rd,
  output logic [`XLEN-1:0] wb_data
);

  // Fixed priority, multiplier first
  assign mul_wb.grant = mul_wb.req;
  assign alu_wb.grant = alu_wb.req && !mul_wb.req;

  // Winner drives the register write port
  assign we    = mul_wb.grant || alu_wb.grant;
  assign waddr = mul_wb.grant ? mul_wb.rd : alu_wb.rd;
  assign wdata = mul_wb.grant ? mul_wb.data : alu_wb.data;

  // Reported write-back mirrors the port
  assign wb_valid = we;
  assign wb_rd    = waddr;
  assign wb_data  = wdata;

  // Producers never ask for x0
  a_no_x0: assert property (@(posedge clk) disable iff (rst)
    we |-> waddr != 5'd0);

  // Mul requests are never back to back, so the ALU slips one cycle at most
  a_alu_slip: assert property (@(posedge clk) disable iff (rst)
    alu_wb.req && !alu_wb.grant |=> alu_wb.grant);

endmodule

// File: hw/exec_core.sv
`include "core_settings.svh"

module exec_core
  import exec_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             inst_valid,
  input  logic [31:0]      inst,
  output logic             stall,
  output logic             wb_valid,
  output logic [4:0]       wb_rd,
  output logic [`XLEN-1:0] wb_data,
  output logic             branch_taken,
  output logic             redirect
);

  logic [4:0]       rs1_addr;
  logic [4:0]       rs2_addr;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic             alu_start;
  logic             mul_start;
  logic             mul_busy;
  logic [4:0]       mul_rd;
  logic             alu_hold;
  issue_t           op;
  logic             rf_we;
  logic [4:0]       rf_waddr;
  logic [`XLEN-1:0] rf_wdata;

  // Write-back paths of the two producers
  wb_if alu_wb ();
  wb_if mul_wb ();

  issue_unit issue_unit_inst (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .mul_busy   (mul_busy),
    .mul_rd     (mul_rd),
    .alu_hold   (alu_hold),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .stall      (stall),
    .alu_start  (alu_start),
    .mul_start  (mul_start),
    .op         (op)
  );

  register_file register_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  alu_stage alu_stage_inst (
    .clk          (clk),
    .rst          (rst),
    .alu_start    (alu_start),
    .op           (op),
    .wb           (alu_wb.producer),
    .branch_taken (branch_taken),
    .redirect     (redirect),
    .alu_hold     (alu_hold)
  );

  iter_multiplier iter_multiplier_inst (
    .clk       (clk),
    .rst       (rst),
    .mul_start (mul_start),
    .op        (op),
    .wb        (mul_wb.producer),
    .mul_busy  (mul_busy),
    .mul_rd    (mul_rd)
  );

  wb_arbiter wb_arbiter_inst (
    .clk      (clk),
    .rst      (rst),
    .alu_wb   (alu_wb.arbiter),
    .mul_wb   (mul_wb.arbiter),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

endmodule

// File: bench/exec_core_tb.sv
`include "core_settings.svh"

module exec_core_tb
  import riscv_isa_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_RANDOM = 240;

  logic             clk;
  logic             rst;
  logic             inst_valid;
  logic [31:0]      inst;
  logic             stall;
  logic             wb_valid;
  logic [4:0]       wb_rd;
  logic [`XLEN-1:0] wb_data;
  logic             branch_taken;
  logic             redirect;

  integer seed;
  int     fail_count;
  int     cycle_count;
  int     cycle_limit;

  // Program, built before reset ends
  logic [31:0] prog_word [$];
  string       prog_name [$];
  int          prog_gap [$];

  // Reference model
  logic [`XLEN-1:0] model_regs [`NUM_REGS];
  logic             squash;
  logic             m_busy;
  int               m_age;
  logic [4:0]       m_rd;
  logic             a_req;
  logic             alu_issued;
  logic             mul_done;
  logic             alu_kept;
  logic             exp_branch;
  logic             exp_redirect;
  logic             exp_stall;

  // Acceptance seen at the falling edge, applied at the next rising edge
  logic             acc_now;
  logic [31:0]      acc_word;
  string            acc_name;
  string            cur_name;
  string            last_name;

  // Expected writes, one set of queues per producer
  logic [4:0]       alu_rd_q [$];
  logic [`XLEN-1:0] alu_data_q [$];
  string            alu_name_q [$];
  logic [4:0]       mul_rd_q [$];
  logic [`XLEN-1:0] mul_data_q [$];
  string            mul_name_q [$];

  exec_core exec_core_inst (
    .clk          (clk),
    .rst          (rst),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .stall        (stall),
    .wb_valid     (wb_valid),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .branch_taken (branch_taken),
    .redirect     (redirect)
  );

  always #20 clk = ~clk;

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // Instruction encoders in assembler operand order
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rd, input int rs1,
                                        input int rs2);
    return {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), OP_R};
  endfunction

  function automatic logic [31:0] enc_i(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), OP_IMM};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1, input int rs2);
    return {7'b0, 5'(rs2), 5'(rs1), f3, 5'b0, OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input int rd, input int imm);
    return {20'(imm), 5'(rd), OP_JAL};
  endfunction

  task automatic push(input logic [31:0] word, input string name, input int gap);
    prog_word.push_back(word);
    prog_name.push_back(name);
    prog_gap.push_back(gap);
  endtask

  task automatic add_random(input int count);
    int         kind;
    int         rd;
    int         rs1;
    int         rs2;
    int         pick;
    logic [6:0] f7;
    for (int n = 0; n < count; n++)
    begin
      kind = rand_below(20);
      rd   = rand_below(8);
      rs1  = rand_below(8);
      rs2  = rand_below(8);
      pick = rand_below(5);
      // Same source twice makes equal compares common
      if (rand_below(4) == 0)
        rs2 = rs1;
      if (kind < 5)
      begin
        f7 = (pick < 2) ? F7_ADD : (pick < 4) ? F7_SUB : 7'(rand_below(128));
        push(enc_r(f7, rd, rs1, rs2), "random_alu", 0);
      end
      else if (kind < 9)
        push(enc_r(F7_MUL, rd, rs1, rs2), "random_mul", 0);
      else if (kind < 14)
        push(enc_i(rd, rs1, rand_below(4096) - 2048), "random_addi", 0);
      else if (kind < 18)
        push(enc_b((pick < 2) ? BR_NE : BR_EQ, rs1, rs2), "random_branch", 0);
      else
        push(enc_j(rd, rand_below(1 << 20)), "random_jal", 0);
      // Occasional idle cycle before the next word
      if (rand_below(5) == 0)
        prog_gap[prog_gap.size() - 1] = 1;
    end
  endtask

  task automatic build_program();
    // Every register is read once while it still holds its reset value
    for (int k = 0; k < 16; k++)
      push(enc_r(F7_ADD, 1 + k % 7, 2 * k, 2 * k + 1), "reset_zero", 0);
    // Dependent ALU ops back to back
    push(enc_i(1, 0, 100), "alu_chain", 0);
    push(enc_i(2, 1, -7), "alu_chain", 0);
    push(enc_r(F7_ADD, 3, 1, 2), "alu_chain", 0);
    push(enc_r(F7_SUB, 4, 3, 2), "alu_chain", 0);
    push(enc_r(F7_ADD, 5, 4, 4), "alu_chain", 0);
    push(enc_i(6, 5, 2047), "alu_chain", 0);
    push(enc_r(F7_SUB, 7, 0, 6), "alu_chain", 0);
    push(enc_r(7'b1111111, 1, 7, 6), "alu_chain", 0);
    // Later ALU writes overtake the multiply
    push(enc_i(1, 0, -3), "mul_order", 0);
    push(enc_i(2, 0, 1234), "mul_order", 0);
    push(enc_r(F7_MUL, 3, 1, 2), "mul_order", 0);
    push(enc_i(4, 0, 9), "mul_order", 0);
    push(enc_r(F7_ADD, 5, 4, 4), "mul_order", 0);
    push(enc_r(F7_SUB, 6, 5, 1), "mul_order", 0);
    push(enc_r(F7_MUL, 7, 5, 6), "mul_order", 0);
    push(enc_r(F7_ADD, 2, 7, 3), "mul_order", 0);
    push(enc_r(F7_MUL, 0, 1, 2), "mul_order", 0);
    push(enc_r(F7_ADD, 1, 3, 0), "mul_order", 0);
    // WAW and RAW on the pending product
    push(enc_r(F7_MUL, 5, 1, 2), "hazard", 0);
    push(enc_i(5, 0, 1), "hazard", 0);
    push(enc_r(F7_MUL, 6, 5, 5), "hazard", 0);
    push(enc_i(3, 6, 0), "hazard", 0);
    push(enc_b(BR_EQ, 6, 6), "hazard", 0);
    // Each jump kills the word after it
    push(enc_j(1, 12), "jal_squash", 0);
    push(enc_i(2, 0, 55), "jal_squash", 0);
    push(enc_i(3, 2, 1), "jal_squash", 0);
    push(enc_j(0, 4), "jal_squash", 0);
    push(enc_r(F7_MUL, 4, 3, 3), "jal_squash", 0);
    push(enc_j(5, 8), "jal_squash", 0);
    push(enc_j(6, 8), "jal_squash", 1);
    push(enc_i(7, 0, 7), "jal_squash", 0);
    push(enc_b(BR_NE, 7, 0), "jal_squash", 0);
    push(enc_b(BR_EQ, 1, 1), "branch", 0);
    push(enc_b(BR_NE, 1, 1), "branch", 0);
    push(enc_b(BR_EQ, 2, 3), "branch", 1);
    push(enc_b(BR_NE, 2, 3), "branch", 0);
    push(enc_b(BR_EQ, 0, 0), "branch", 0);
    add_random(N_RANDOM);
  endtask

  task automatic reset_model();
    for (int i = 0; i < `NUM_REGS; i++)
      model_regs[i] = '0;
    squash       = 1'b0;
    m_busy       = 1'b0;
    m_age        = 0;
    m_rd         = '0;
    a_req        = 1'b0;
    exp_branch   = 1'b0;
    exp_redirect = 1'b0;
    alu_rd_q.delete();
    alu_data_q.delete();
    alu_name_q.delete();
    mul_rd_q.delete();
    mul_data_q.delete();
    mul_name_q.delete();
  endtask

  // Program order update of the model at acceptance
  task automatic apply_inst(input logic [31:0] w, input string name);
    logic [6:0]       opc;
    logic [4:0]       rd;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] res;
    opc = w[6:0];
    rd  = w[11:7];
    a   = model_regs[w[19:15]];
    b   = model_regs[w[24:20]];
    if (squash)
      squash = 1'b0;
    else if (opc == OP_R && w[31:25] == F7_MUL)
    begin
      // Product into x0 is dropped
      if (rd != 5'd0)
      begin
        res            = a * b;
        model_regs[rd] = res;
        mul_rd_q.push_back(rd);
        mul_data_q.push_back(res);
        mul_name_q.push_back(name);
        m_busy = 1'b1;
        m_age  = 1;
        m_rd   = rd;
      end
    end
    else if (opc == OP_R || opc == OP_IMM)
    begin
      if (opc == OP_IMM)
        res = a + {{(`XLEN - 12){w[31]}}, w[31:20]};
      else if (w[31:25] == F7_SUB)
        res = a - b;
      else
        res = a + b;
      if (rd != 5'd0)
      begin
        model_regs[rd] = res;
        alu_rd_q.push_back(rd);
        alu_data_q.push_back(res);
        alu_name_q.push_back(name);
        alu_issued = 1'b1;
      end
    end
    else if (opc == OP_BRANCH)
      exp_branch = (w[14:12] == BR_EQ) ? (a == b) : (a != b);
    else if (opc == OP_JAL)
    begin
      exp_redirect = 1'b1;
      squash       = 1'b1;
    end
  endtask

  // Word blocked by the pending multiply
  function automatic logic mul_hazard(input logic [31:0] w);
    logic [6:0] opc;
    logic       is_mul;
    logic       reads1;
    logic       reads2;
    logic       writes;
    opc    = w[6:0];
    is_mul = (opc == OP_R) && (w[31:25] == F7_MUL);
    reads1 = (opc == OP_R) || (opc == OP_IMM) || (opc == OP_BRANCH);
    reads2 = (opc == OP_R) || (opc == OP_BRANCH);
    writes = ((opc == OP_R) || (opc == OP_IMM)) && (w[11:7] != 5'd0);
    return m_busy && (is_mul || (reads1 && w[19:15] == m_rd)
           || (reads2 && w[24:20] == m_rd) || (writes && w[11:7] == m_rd));
  endfunction

  task automatic stop_on_error();
    fail_count++;
    $display("Simulation FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_wb(input string test, input logic [4:0] exp_rd,
                          input logic [`XLEN-1:0] exp_data);
    if (wb_rd !== exp_rd || wb_data !== exp_data)
    begin
      $display("[FAIL] %s: write-back expected x%0d = %h, actual x%0d = %h",
               test, exp_rd, exp_data, wb_rd, wb_data);
      stop_on_error();
    end
  endtask

  task automatic check_branch(input string test, input logic exp);
    if (branch_taken !== exp)
    begin
      $display("[FAIL] %s: branch_taken expected %b, actual %b", test, exp, branch_taken);
      stop_on_error();
    end
  endtask

  task automatic check_redirect(input string test, input logic exp);
    if (redirect !== exp)
    begin
      $display("[FAIL] %s: redirect expected %b, actual %b", test, exp, redirect);
      stop_on_error();
    end
  endtask

  task automatic check_stall(input string test, input logic exp);
    if (stall !== exp)
    begin
      $display("[FAIL] %s: stall expected %b, actual %b", test, exp, stall);
      stop_on_error();
    end
  endtask

  // Producer that owns the write port this cycle supplies the reference write
  task automatic retire_writeback(input logic exp_mul, input logic exp_alu);
    if (wb_valid !== (exp_mul || exp_alu))
    begin
      $display("[FAIL] %s: wb_valid expected %b, actual %b", last_name,
               exp_mul || exp_alu, wb_valid);
      stop_on_error();
    end
    else if (wb_valid && wb_rd == 5'd0)
    begin
      $display("A write-back to x0 was reported");
      stop_on_error();
    end
    else if (exp_mul)
      check_wb(mul_name_q.pop_front(), mul_rd_q.pop_front(), mul_data_q.pop_front());
    else if (exp_alu)
      check_wb(alu_name_q.pop_front(), alu_rd_q.pop_front(), alu_data_q.pop_front());
  endtask

  // Mid-cycle checks, all outputs settled
  always @(negedge clk)
  begin
    if (rst)
      acc_now = 1'b0;
    else
    begin
      mul_done  = m_busy && (m_age == `MUL_STEPS);
      exp_stall = inst_valid && ((a_req && mul_done) || mul_hazard(inst));
      check_stall(cur_name, exp_stall);
      check_branch(last_name, exp_branch);
      check_redirect(last_name, exp_redirect);
      retire_writeback(mul_done, a_req);
      acc_now  = inst_valid && !exp_stall;
      acc_word = inst;
      acc_name = cur_name;
    end
  end

  // Model state advances on the same edges as the DUT
  always @(posedge clk)
  begin
    if (rst)
      reset_model();
    else
    begin
      mul_done     = m_busy && (m_age == `MUL_STEPS);
      // ALU request that lost to the multiplier stays one more cycle
      alu_kept     = a_req && mul_done;
      alu_issued   = 1'b0;
      exp_branch   = 1'b0;
      exp_redirect = 1'b0;
      if (mul_done)
        m_busy = 1'b0;
      else if (m_busy)
        m_age = m_age + 1;
      if (acc_now)
      begin
        last_name = acc_name;
        apply_inst(acc_word, acc_name);
      end
      a_req = alu_kept || alu_issued;
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      stop_on_error();
    end
  end

  // Present a word and hold it until the DUT takes it
  task automatic send(input logic [31:0] word, input string name);
    inst       = word;
    inst_valid = 1'b1;
    cur_name   = name;
    @(posedge clk);
    while (!acc_now)
      @(posedge clk);
    #2;
  endtask

  task automatic idle_cycle();
    logic [31:0] junk;
    junk       = $random(seed);
    inst_valid = 1'b0;
    inst       = junk;
    @(posedge clk);
    #2;
  endtask

  initial
  begin
    seed        = 49;
    fail_count  = 0;
    cycle_count = 0;
    rst         = 1'b1;
    clk         = 1'b0;
    inst_valid  = 1'b0;
    inst        = '0;
    cur_name    = "reset";
    last_name   = "reset";
    build_program();
    cycle_limit = prog_word.size() * (`MUL_STEPS + 3) + 50;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    for (int i = 0; i < prog_word.size(); i++)
    begin
      repeat (prog_gap[i]) idle_cycle();
      send(prog_word[i], prog_name[i]);
    end
    inst_valid = 1'b0;
    cur_name   = "drain";
    // Wait for every expected write to retire
    while (alu_rd_q.size() != 0 || mul_rd_q.size() != 0 || m_busy || a_req)
    begin
      @(posedge clk);
      #2;
    end
    repeat (3) @(posedge clk);
    if (fail_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: exec_core.f
+incdir+include
hw/riscv_isa_pkg.sv
hw/exec_pkg.sv
hw/wb_if.sv
hw/alu_control.sv
hw/issue_unit.sv
hw/register_file.sv
hw/alu_stage.sv
hw/iter_multiplier.sv
hw/wb_arbiter.sv
hw/exec_core.sv
bench/exec_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the exec_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module exec_core_tb \
  -f exec_core.f \
  -o Vexec_core_tb

# Status comes from the log
./obj_dir/Vexec_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
echo "Run failed, see sim.log"
exit 1
